// ==== Bender.yml ====
package:
  name: cache

sources:
  # Packages first, then modules in dependency order.
  - logic/cache_pkg.sv
  - logic/axi_lite_pkg.sv
  - logic/cache_controller.sv
  - logic/cache_datapath.sv
  - logic/axi_lite_memory.sv
  - logic/cache.sv

  - target: test
    files:
      - verification/cache_sva.sv
      - verification/cache_tb.sv

# Simulation tops: cache_tb for the testbench, cache for the RTL.
# Stimulus file: verification/cache_patterns.txt, read from the project root.
# File list for direct tool use: cache.f.
# Run the simulator from the project root.
# No include directories are needed.

// ==== cache.f ====
logic/cache_pkg.sv
logic/axi_lite_pkg.sv
logic/cache_controller.sv
logic/cache_datapath.sv
logic/axi_lite_memory.sv
logic/cache.sv
verification/cache_sva.sv
verification/cache_tb.sv

// ==== logic/axi_lite_memory.sv ====
// Behavioral AXI4-Lite slave, cleared at reset, always answers OKAY.
// Addresses wrap at MEM_WORDS words; AW and W are taken only together.

`timescale 1ns/100ps

module axi_lite_memory #(
    parameter int ADDR_WIDTH = 16,
    parameter int MEM_WORDS  = 1024
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output axi_lite_pkg::resp_e                     rresp,
    output logic                                    rvalid,
    input  logic                                    rready,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                                    wvalid,
    output logic                                    wready,
    output axi_lite_pkg::resp_e                     bresp,
    output logic                                    bvalid,
    input  logic                                    bready
);

    localparam int WORD_BITS = ADDR_WIDTH - cache_pkg::BYTE_OFFSET;
    localparam int IDX_BITS  = $clog2(MEM_WORDS);

    logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [WORD_BITS-1:0] rd_word, wr_word;

    assign rd_word = araddr[ADDR_WIDTH-1:cache_pkg::BYTE_OFFSET];
    assign wr_word = awaddr[ADDR_WIDTH-1:cache_pkg::BYTE_OFFSET];

    // No new address while a response waits.
    assign arready = !rvalid;
    assign awready = !bvalid && awvalid && wvalid;
    assign wready  = awready;

    assign rresp = axi_lite_pkg::OKAY;
    assign bresp = axi_lite_pkg::OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) mem[i] <= '0;
        end else begin
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rdata  <= mem[rd_word[IDX_BITS-1:0]];
            end else if (rready) begin
                rvalid <= 1'b0;  // Held until taken.
            end
            if (awvalid && awready) begin
                bvalid <= 1'b1;
                mem[wr_word[IDX_BITS-1:0]] <= wdata;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/axi_lite_pkg.sv ====
// AXI4-Lite bus widths and response codes.
// Only OKAY and SLVERR are modelled.

package axi_lite_pkg;

    // Byte address and data widths on the memory bus.
    parameter int AXI_ADDR_WIDTH = 32;
    parameter int AXI_DATA_WIDTH = 32;

    // RRESP and BRESP encodings.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage

// ==== logic/cache.sv ====
// Write-through, no-write-allocate data cache with its AXI4-Lite memory.
// One request at a time; see cache_controller for the handshake rules.

`timescale 1ns/100ps

module cache #(
    parameter int ADDR_WIDTH = 16,
    parameter int NUM_LINES  = 8,
    parameter int MEM_WORDS  = 1024
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  cache_pkg::word_t      wdata,
    output logic                  ready,
    output logic                  valid,
    output cache_pkg::word_t      rdata
);

    logic hit, req_write, capture, fill, hit_update;

    // AXI4-Lite bus between cache and memory.
    logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr, awaddr;
    logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] axi_rdata, axi_wdata;
    logic arvalid, arready, rvalid, rready;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    axi_lite_pkg::resp_e rresp, bresp;

    cache_controller i_controller (
        .clk, .rst_n, .req, .ready, .valid,
        .hit, .req_write, .capture, .fill, .hit_update,
        .arvalid, .arready, .rvalid, .rready, .rresp,
        .awvalid, .awready, .wvalid, .wready, .bvalid, .bready, .bresp
    );

    cache_datapath #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_LINES  (NUM_LINES)
    ) i_datapath (
        .clk, .rst_n, .addr, .wdata, .write,
        .capture, .fill, .hit_update, .hit, .req_write, .rdata,
        .araddr, .awaddr,
        .wdata_axi (axi_wdata),
        .rdata_axi (axi_rdata)
    );

    axi_lite_memory #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS)
    ) i_memory (
        .clk, .rst_n,
        .araddr, .arvalid, .arready,
        .rdata (axi_rdata),
        .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready,
        .wdata (axi_wdata),
        .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

endmodule

// ==== logic/cache_controller.sv ====
// Blocking cache FSM, one request in flight at a time.
// Assumes the processor holds req, write, addr and wdata until valid.
// An error response completes normally but leaves the cache untouched.

`timescale 1ns/100ps

module cache_controller (
    input  logic                  clk,
    input  logic                  rst_n,

    // Processor handshake.
    input  logic                  req,
    output logic                  ready,
    output logic                  valid,

    // Datapath status and strobes.
    input  logic                  hit,
    input  logic                  req_write,
    output logic                  capture,
    output logic                  fill,
    output logic                  hit_update,

    // AXI4-Lite read channels.
    output logic                  arvalid,
    input  logic                  arready,
    input  logic                  rvalid,
    output logic                  rready,
    input  axi_lite_pkg::resp_e   rresp,

    // AXI4-Lite write channels.
    output logic                  awvalid,
    input  logic                  awready,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    input  axi_lite_pkg::resp_e   bresp
);

    cache_pkg::cache_state_e state_q, state_d;

    logic aw_done_q;  // AW already taken in this WRITE_REQ.
    logic w_done_q;
    logic aw_fire;
    logic w_fire;
    logic write_sent;

    assign ready   = (state_q == cache_pkg::IDLE);
    assign valid   = (state_q == cache_pkg::RESPOND);
    assign capture = ready && req;

    assign arvalid = (state_q == cache_pkg::READ_ADDR);
    assign rready  = (state_q == cache_pkg::READ_DATA);
    assign awvalid = (state_q == cache_pkg::WRITE_REQ) && !aw_done_q;
    assign wvalid  = (state_q == cache_pkg::WRITE_REQ) && !w_done_q;
    assign bready  = (state_q == cache_pkg::WRITE_RESP);

    assign aw_fire    = awvalid && awready;
    assign w_fire     = wvalid && wready;
    assign write_sent = (aw_done_q || aw_fire) && (w_done_q || w_fire);

    // Install read data only when memory reports success.
    assign fill = rready && rvalid && (rresp == axi_lite_pkg::OKAY);

    // Write hit refreshes the line once memory has taken the word.
    assign hit_update = bready && bvalid && hit && (bresp == axi_lite_pkg::OKAY);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            cache_pkg::IDLE: begin
                if (capture) state_d = cache_pkg::LOOKUP;
            end
            cache_pkg::LOOKUP: begin
                if (req_write)
                    state_d = cache_pkg::WRITE_REQ;  // Write-through, hit or miss.
                else if (hit)
                    state_d = cache_pkg::RESPOND;
                else
                    state_d = cache_pkg::READ_ADDR;
            end
            cache_pkg::READ_ADDR: begin
                if (arready) state_d = cache_pkg::READ_DATA;
            end
            cache_pkg::READ_DATA: begin
                if (rvalid) state_d = cache_pkg::RESPOND;
            end
            cache_pkg::WRITE_REQ: begin
                if (write_sent) state_d = cache_pkg::WRITE_RESP;
            end
            cache_pkg::WRITE_RESP: begin
                if (bvalid) state_d = cache_pkg::RESPOND;
            end
            cache_pkg::RESPOND: begin
                state_d = cache_pkg::IDLE;
            end
            default: state_d = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= cache_pkg::IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_pkg::WRITE_REQ && !write_sent) begin
                aw_done_q <= aw_done_q || aw_fire;
                w_done_q  <= w_done_q || w_fire;
            end else begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/cache_datapath.sv ====
// Direct-mapped arrays, one word per line, NUM_LINES a power of two.
// Tag and data arrays are not cleared; only the valid bits reset.
// Bus addresses are word aligned and zero extended to the AXI width.

`timescale 1ns/100ps

module cache_datapath #(
    parameter int ADDR_WIDTH = 16,
    parameter int NUM_LINES  = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,

    // Processor request.
    input  logic [ADDR_WIDTH-1:0]                   addr,
    input  cache_pkg::word_t                        wdata,
    input  logic                                    write,

    // Controller strobes and status.
    input  logic                                    capture,
    input  logic                                    fill,
    input  logic                                    hit_update,
    output logic                                    hit,
    output logic                                    req_write,
    output cache_pkg::word_t                        rdata,

    // Memory bus payload.
    output logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    output logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata_axi,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata_axi
);

    localparam int OFFSET_BITS = cache_pkg::BYTE_OFFSET;
    localparam int INDEX_BITS  = $clog2(NUM_LINES);
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int AXI_AW      = axi_lite_pkg::AXI_ADDR_WIDTH;

    // Latched request.
    logic [ADDR_WIDTH-1:0] addr_q;
    cache_pkg::word_t      wdata_q;
    logic                  write_q;

    // Line storage.
    logic [TAG_BITS-1:0]   tag_q   [NUM_LINES];
    cache_pkg::word_t      data_q  [NUM_LINES];
    logic [NUM_LINES-1:0]  valid_q;

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic [ADDR_WIDTH-1:0] word_addr;

    assign index = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign tag   = addr_q[ADDR_WIDTH-1 -: TAG_BITS];

    assign hit       = valid_q[index] && (tag_q[index] == tag);
    assign req_write = write_q;

    // After a fill the line holds the fetched word, so one read port serves both cases.
    assign rdata = data_q[index];

    assign word_addr = {addr_q[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign araddr    = AXI_AW'(word_addr);
    assign awaddr    = AXI_AW'(word_addr);
    assign wdata_axi = wdata_q;

    always_ff @(posedge clk) begin
        if (capture) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            write_q <= write;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index]  <= tag;
            data_q[index] <= rdata_axi;
        end else if (hit_update) begin
            data_q[index] <= wdata_q;  // Keep the line in step with memory.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
        end
    end

endmodule

// ==== logic/cache_pkg.sv ====
// Cache-wide word type and controller state encoding.
// Data words are 32 bits and byte addressed, so the low two address bits are ignored.

package cache_pkg;

    // Processor data word.
    parameter int DATA_WIDTH = 32;

    // Address bits that select a byte inside a word.
    parameter int BYTE_OFFSET = $clog2(DATA_WIDTH / 8);

    typedef logic [DATA_WIDTH-1:0] word_t;

    // Controller states.
    // A read hit passes IDLE, LOOKUP and RESPOND only.
    // A read miss adds READ_ADDR and READ_DATA.
    // A write, hit or miss, adds WRITE_REQ and WRITE_RESP.
    typedef enum logic [2:0] {
        IDLE       = 3'd0,  // Waiting for a request.
        LOOKUP     = 3'd1,  // Tag compare on the latched request.
        READ_ADDR  = 3'd2,  // AR channel.
        READ_DATA  = 3'd3,  // R channel.
        WRITE_REQ  = 3'd4,  // AW and W channels.
        WRITE_RESP = 3'd5,  // B channel.
        RESPOND    = 3'd6   // One-cycle valid to the processor.
    } cache_state_e;

endpackage

// ==== verification/cache_patterns.txt ====
# kind (0 read, 1 write), byte address, write data, expected read data; all hex
# Memory starts cleared; lines 0010, 0030 and 0050 share cache index 4
0 0000 00000000 00000000
0 0000 00000000 00000000
1 0004 deadbeef 00000000
0 0004 00000000 deadbeef
0 0004 00000000 deadbeef
1 0004 12345678 00000000
0 0004 00000000 12345678
1 0010 aaaa0010 00000000
1 0030 bbbb0030 00000000
0 0010 00000000 aaaa0010
0 0030 00000000 bbbb0030
0 0010 00000000 aaaa0010
1 0030 cccc0030 00000000
0 0030 00000000 cccc0030
0 0010 00000000 aaaa0010
1 0050 55550050 00000000
0 0050 00000000 55550050
0 0030 00000000 cccc0030
0 0ffc 00000000 00000000
1 0ffc 0badf00d 00000000
0 0ffc 00000000 0badf00d

// ==== verification/cache_sva.sv ====
// Handshake assertions, bound into every cache_controller instance.
// Disabled while rst_n is low.

`timescale 1ns/100ps

module cache_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    ready,
    input logic                    valid,
    input logic                    arvalid,
    input logic                    arready,
    input logic                    awvalid,
    input logic                    awready,
    input cache_pkg::cache_state_e state
);

    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        valid |=> !valid)
        else $error("valid high in two consecutive cycles");

    arvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    awvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    // A busy cache reopens only through the RESPOND cycle.
    ready_after_respond: assert property (@(posedge clk) disable iff (!rst_n)
        state != cache_pkg::IDLE && !valid |=> !ready)
        else $error("ready rose without a valid pulse");

endmodule

bind cache_controller cache_sva i_sva (
    .clk, .rst_n, .ready, .valid, .arvalid, .arready, .awvalid, .awready,
    .state (state_q)
);

// ==== verification/cache_tb.sv ====
// Drives the cache from the pattern file, then from a seeded random stream.
// Reference memory and shadow tags assume 8 lines, 1024 words, addresses below 0x1000.

`timescale 1ns/100ps

module cache_tb;

    localparam int ADDR_WIDTH = 16;
    localparam int NUM_LINES  = 8;
    localparam int MEM_WORDS  = 1024;
    localparam int TIMEOUT    = 200;
    localparam int RANDOM_OPS = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    cache_pkg::word_t      wdata;
    logic                  ready;
    logic                  valid;
    cache_pkg::word_t      rdata;

    cache_pkg::word_t ref_mem [MEM_WORDS];  // Expected memory contents.
    logic             line_valid [NUM_LINES];
    logic [10:0]      line_tag [NUM_LINES];

    int          pulse_count = 0;
    int          ops_done = 0;
    integer      seed;
    integer      fd;
    integer      n;
    string       line;
    logic [31:0] kind, pat_addr, pat_data, pat_exp;

    cache #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_LINES  (NUM_LINES),
        .MEM_WORDS  (MEM_WORDS)
    ) i_dut (
        .clk, .rst_n, .req, .write, .addr, .wdata, .ready, .valid, .rdata
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Valid is one cycle wide, so one falling edge per pulse.
    always @(negedge clk) if (rst_n && valid) pulse_count++;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation stopped.");
        end
    endtask

    // One processor request; latency counts edges from acceptance to valid.
    task automatic run_request(input logic is_write, input logic [ADDR_WIDTH-1:0] a,
                               input cache_pkg::word_t d, output cache_pkg::word_t got,
                               output int latency);
        int waited;
        waited = 0;
        @(negedge clk);
        req   = 1'b1;
        write = is_write;
        addr  = a;
        wdata = d;
        while (!ready) begin
            if (waited >= TIMEOUT) abort_run("Timed out waiting for the cache to be ready.");
            @(negedge clk);
            waited++;
        end
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (latency > TIMEOUT) abort_run("Timed out waiting for valid from the cache.");
        end while (!valid);
        got = rdata;
        req = 1'b0;  // Dropped before the cache is back in IDLE.
        @(posedge clk);
    endtask

    task automatic do_op(input logic is_write, input logic [ADDR_WIDTH-1:0] a,
                         input cache_pkg::word_t d, input cache_pkg::word_t exp,
                         input logic use_exp);
        cache_pkg::word_t got;
        int               latency;
        logic [9:0]       word;
        logic [2:0]       idx;
        logic             predict_hit;
        word        = a[11:2];
        idx         = a[4:2];
        predict_hit = line_valid[idx] && (line_tag[idx] == a[15:5]);
        run_request(is_write, a, d, got, latency);
        ops_done++;
        check(pulse_count, ops_done, "valid pulses per request");
        if (is_write) begin
            ref_mem[word] = d;  // No allocate, shadow tags unchanged.
            check(latency > 2, 1, "write latency beyond lookup");
        end else begin
            check(got, ref_mem[word], "read data against reference memory");
            if (use_exp) check(got, exp, "read data against pattern file");
            if (predict_hit) begin
                check(latency, 2, "read hit latency");
            end else begin
                check(latency > 2, 1, "read miss latency beyond lookup");
                line_valid[idx] = 1'b1;
                line_tag[idx]   = a[15:5];
            end
        end
    endtask

    initial begin
        seed  = 32'h9eac;
        rst_n = 1'b0;
        req   = 1'b0;
        write = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check(ready, 1, "ready after reset");
        check(valid, 0, "valid after reset");

        fd = $fopen("verification/cache_patterns.txt", "r");
        if (fd == 0) abort_run("Could not open the pattern file.");
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h", kind, pat_addr, pat_data, pat_exp);
            if (n <= 0) continue;  // Blank line.
            if (n != 4 || kind > 1) abort_run("Malformed line in the pattern file.");
            do_op(kind[0], pat_addr[ADDR_WIDTH-1:0], pat_data, pat_exp, 1'b1);
        end
        $fclose(fd);

        // 64 words over 8 lines keeps conflicts frequent.
        for (int i = 0; i < RANDOM_OPS; i++) begin
            pat_addr = ($random(seed) & 32'h3f) << 2;
            kind     = $random(seed) & 32'h1;
            pat_data = $random(seed);
            do_op(kind[0], pat_addr[ADDR_WIDTH-1:0], pat_data, '0, 1'b0);
        end

        repeat (4) @(negedge clk);
        check(pulse_count, ops_done, "valid pulses after the last request");
        $display("STATUS: PASS");
        $finish;
    end

endmodule
